// File: rtl/jsp_pkg.sv
// Shared widths, payload types and FSM encodings for the JTAG serial port.
// Every RTL file except the interfaces imports this package by wildcard.

package jsp_pkg;

  ///////////////////////////////
  // Widths
  ///////////////////////////////

  localparam int BYTE_W    = 8;                     // Serial word, one byte
  localparam int CNT_W     = 4;                     // Byte counts travel as nibbles
  localparam int BIT_CNT_W = 3;                     // Index of a bit inside a byte

  localparam logic [BIT_CNT_W-1:0] BIT_LAST = 3'd7; // Final bit of each byte

  ///////////////////////////////
  // Payload types
  ///////////////////////////////

  typedef logic [BYTE_W-1:0]    byte_t;
  typedef logic [CNT_W-1:0]     count_t;
  typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

  ///////////////////////////////
  // FSM states
  ///////////////////////////////

  // Host-to-target channel
  typedef enum logic [1:0] {
    WR_IDLE   = 2'd0,  // Not selected or after update
    WR_WAIT   = 2'd1,  // Waiting for the '1' start bit
    WR_COUNTS = 2'd2,  // Assembling the count byte
    WR_XFER   = 2'd3   // Assembling data bytes
  } wr_state_e;

  // Target-to-host channel
  typedef enum logic [1:0] {
    RD_IDLE   = 2'd0,
    RD_COUNTS = 2'd1,  // Status byte going out
    RD_RDACK  = 2'd2,  // One shift to ack the byte just loaded
    RD_XFER   = 2'd3   // Rest of a data byte going out
  } rd_state_e;

endpackage

// File: rtl/jsp_if.sv
// Control bundles between the controller and the two shift paths.
// The controller takes the ctrl modport, the rx or tx path takes path.

// Receive side, host to target
interface jsp_rx_if;

  logic       bit_rst;   // Zero the write bit counter
  logic       bit_en;    // Count one bit and shift TDI in
  logic       bit_last;  // Counter sits on bit 7
  logic [7:0] rx_byte;   // Live TDI on top of seven shifted bits

  modport ctrl (
    output bit_rst,
    output bit_en,
    input  bit_last
  );

  modport path (
    input  bit_rst,
    input  bit_en,
    output bit_last,
    output rx_byte
  );

endinterface

// Transmit side, target to host
interface jsp_tx_if;

  logic bit_rst;     // Zero the read bit counter
  logic bit_en;      // Count one bit out
  logic load;        // Parallel load of the output register
  logic shift;       // Shift right, zero fill
  logic sel_status;  // Load the status byte, else the bus byte
  logic bit_last;

  modport ctrl (
    output bit_rst,
    output bit_en,
    output load,
    output shift,
    output sel_status,
    input  bit_last
  );

  modport path (
    input  bit_rst,
    input  bit_en,
    input  load,
    input  shift,
    input  sel_status,
    output bit_last
  );

endinterface

// File: rtl/jsp_word_counter.sv
// Loadable down counter for byte counts, used three times at the top.
// Load wins over decrement; zero_o flags an empty count.

module jsp_word_counter import jsp_pkg::*; (
  input  logic   tck_i,
  input  logic   rst_i,
  input  logic   load_i,
  input  logic   dec_i,
  input  count_t value_i,
  output logic   zero_o
);

  count_t cnt_q;

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= value_i;
    end else if (dec_i) begin
      cnt_q <= cnt_q - 1'b1;  // Controller only decrements when nonzero
    end
  end

  assign zero_o = (cnt_q == '0);

endmodule

// File: rtl/jsp_rx_path.sv
// Receive path of the write channel.
// Counts bits shifted in and keeps the seven previous TDI bits, so the
// assembled byte is ready in the same cycle as its eighth bit.

module jsp_rx_path import jsp_pkg::*; (
  input  logic   tck_i,
  input  logic   rst_i,
  input  logic   tdi_i,
  jsp_rx_if.path rx
);

  bit_cnt_t          bit_cnt_q;
  logic [BYTE_W-2:0] shreg_q;  // Seven bits, LSB arrived first

  //////////////////////////////
  // Bit counter
  //////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      bit_cnt_q <= '0;
    end else if (rx.bit_rst) begin
      bit_cnt_q <= '0;  // Reset beats enable on the last bit
    end else if (rx.bit_en) begin
      bit_cnt_q <= bit_cnt_q + 1'b1;
    end
  end

  assign rx.bit_last = (bit_cnt_q == BIT_LAST);

  //////////////////////////////
  // Receive shift register
  //////////////////////////////

  // Shifts right, new bit enters at the top
  always_ff @(posedge tck_i) begin
    if (rx.bit_en) begin
      shreg_q <= {tdi_i, shreg_q[BYTE_W-2:1]};
    end
  end

  // Current TDI completes the byte without waiting a cycle
  assign rx.rx_byte = {tdi_i, shreg_q};

endmodule

// File: rtl/jsp_tx_path.sv
// Transmit path of the read channel.
// Read bit counter plus the parallel-load output register that drives TDO.
// The register loads either the status byte or the bus byte, then shifts
// out LSB first with zero fill.

module jsp_tx_path import jsp_pkg::*; (
  input  logic   tck_i,
  input  logic   rst_i,
  input  byte_t  rd_byte_i,
  input  count_t bytes_avail_i,
  input  count_t bytes_free_i,
  output logic   tdo_o,
  jsp_tx_if.path tx
);

  bit_cnt_t bit_cnt_q;
  byte_t    out_q;
  byte_t    load_data;

  //////////////////////////////
  // Bit counter
  //////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      bit_cnt_q <= '0;
    end else if (tx.bit_rst) begin
      bit_cnt_q <= '0;
    end else if (tx.bit_en) begin
      bit_cnt_q <= bit_cnt_q + 1'b1;
    end
  end

  assign tx.bit_last = (bit_cnt_q == BIT_LAST);

  //////////////////////////////
  // Output register
  //////////////////////////////

  // Status is avail in the high nibble, free in the low nibble
  assign load_data = tx.sel_status ? {bytes_avail_i, bytes_free_i} : rd_byte_i;

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      out_q <= '0;  // TDO low out of reset
    end else if (tx.load) begin
      out_q <= load_data;
    end else if (tx.shift) begin
      out_q <= {1'b0, out_q[BYTE_W-1:1]};
    end
  end

  assign tdo_o = out_q[0];  // LSB first

endmodule

// File: rtl/jsp_ctrl.sv
// Write and read state machines of the JTAG serial port.
// Turns TAP levels into bit counter, shift register and word counter
// enables, and issues the one-cycle bus strobes. All count-zero gating
// is decided here.

module jsp_ctrl import jsp_pkg::*; (
  input  logic   tck_i,
  input  logic   rst_i,
  input  logic   tdi_i,
  input  logic   capture_dr_i,
  input  logic   shift_dr_i,
  input  logic   update_dr_i,
  input  logic   module_select_i,
  jsp_rx_if.ctrl rx,
  jsp_tx_if.ctrl tx,
  output logic   space_load_o,  // Free space in bus side
  output logic   space_dec_o,
  input  logic   space_zero_i,
  output logic   out_load_o,    // Bytes available from bus side
  output logic   out_dec_o,
  input  logic   out_zero_i,
  output logic   user_load_o,   // Bytes the host means to send
  output logic   user_dec_o,
  input  logic   user_zero_i,
  output logic   wr_strobe_o,
  output logic   rd_strobe_o
);

  wr_state_e wr_state_q, wr_state_d;
  rd_state_e rd_state_q, rd_state_d;

  //////////////////////////////
  // Write channel
  //////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      wr_state_q <= WR_IDLE;
    end else begin
      wr_state_q <= wr_state_d;
    end
  end

  always_comb begin
    wr_state_d   = wr_state_q;
    rx.bit_rst   = 1'b0;
    rx.bit_en    = 1'b0;
    space_load_o = 1'b0;
    space_dec_o  = 1'b0;
    user_load_o  = 1'b0;
    user_dec_o   = 1'b0;
    wr_strobe_o  = 1'b0;
    case (wr_state_q)
      WR_IDLE: begin
        if (module_select_i && capture_dr_i) begin
          wr_state_d   = WR_WAIT;
          rx.bit_rst   = 1'b1;
          space_load_o = 1'b1;  // Snapshot of free space
        end
      end
      WR_WAIT: begin
        if (update_dr_i) begin
          wr_state_d = WR_IDLE;
        end else if (module_select_i && tdi_i) begin
          wr_state_d = WR_COUNTS;  // Start bit seen, not counted
        end
      end
      WR_COUNTS: begin
        if (update_dr_i) begin
          wr_state_d = WR_IDLE;
        end else if (shift_dr_i) begin  // Pause holds everything
          rx.bit_en = 1'b1;
          if (rx.bit_last) begin
            rx.bit_rst  = 1'b1;
            user_load_o = 1'b1;  // High nibble of the count byte
            wr_state_d  = WR_XFER;
          end
        end
      end
      WR_XFER: begin
        if (update_dr_i) begin
          wr_state_d = WR_IDLE;
        end else if (shift_dr_i) begin
          rx.bit_en = 1'b1;
          if (rx.bit_last) begin
            rx.bit_rst = 1'b1;
            // Host and bus side must both still have room
            if (!(space_zero_i || user_zero_i)) begin
              wr_strobe_o = 1'b1;
              space_dec_o = 1'b1;
              user_dec_o  = 1'b1;
            end
          end
        end
      end
      default: wr_state_d = WR_IDLE;
    endcase
  end

  //////////////////////////////
  // Read channel
  //////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      rd_state_q <= RD_IDLE;
    end else begin
      rd_state_q <= rd_state_d;
    end
  end

  always_comb begin
    rd_state_d    = rd_state_q;
    tx.bit_rst    = 1'b0;
    tx.bit_en     = 1'b0;
    tx.load       = 1'b0;
    tx.shift      = 1'b0;
    tx.sel_status = 1'b0;
    out_load_o    = 1'b0;
    out_dec_o     = 1'b0;
    rd_strobe_o   = 1'b0;
    case (rd_state_q)
      RD_IDLE: begin
        if (module_select_i && capture_dr_i) begin
          rd_state_d    = RD_COUNTS;
          tx.bit_rst    = 1'b1;
          tx.load       = 1'b1;
          tx.sel_status = 1'b1;  // Status byte first
          out_load_o    = 1'b1;
        end
      end
      RD_COUNTS: begin
        if (update_dr_i) begin
          rd_state_d = RD_IDLE;
        end else if (shift_dr_i) begin
          tx.bit_en = 1'b1;
          tx.shift  = 1'b1;
          if (tx.bit_last) begin
            tx.bit_rst = 1'b1;
            if (!out_zero_i) begin
              tx.load    = 1'b1;  // Load wins over the shift
              rd_state_d = RD_RDACK;
            end else begin
              rd_state_d = RD_XFER;  // Nothing to send, zeros follow
            end
          end
        end
      end
      RD_RDACK: begin
        if (update_dr_i) begin
          rd_state_d = RD_IDLE;
        end else if (shift_dr_i) begin
          tx.bit_en   = 1'b1;
          tx.shift    = 1'b1;
          rd_strobe_o = !out_zero_i;  // Ack the byte now in the register
          rd_state_d  = RD_XFER;
        end
      end
      RD_XFER: begin
        if (update_dr_i) begin
          rd_state_d = RD_IDLE;
        end else if (shift_dr_i) begin
          tx.bit_en = 1'b1;
          tx.shift  = 1'b1;
          if (tx.bit_last) begin
            tx.bit_rst = 1'b1;
            if (!out_zero_i) begin
              tx.load    = 1'b1;
              out_dec_o  = 1'b1;
              rd_state_d = RD_RDACK;
            end
          end
        end
      end
      default: rd_state_d = RD_IDLE;
    endcase
  end

endmodule

// File: rtl/jsp_top.sv
// Top level of the JTAG serial port.
// Takes the TAP levels and TDI on the TCK side and offers plain byte,
// count and strobe ports to the bus side. The bus side latches wr_byte_o
// on wr_strobe_o and advances rd_byte_i on rd_strobe_o.

module jsp_top import jsp_pkg::*; (
  input  logic   tck_i,
  input  logic   rst_i,
  input  logic   tdi_i,
  input  logic   capture_dr_i,
  input  logic   shift_dr_i,
  input  logic   update_dr_i,
  input  logic   module_select_i,
  input  byte_t  rd_byte_i,      // Byte presented by the bus side
  input  count_t bytes_avail_i,  // Bytes waiting for the host
  input  count_t bytes_free_i,   // Room for host bytes
  output logic   tdo_o,
  output byte_t  wr_byte_o,
  output logic   wr_strobe_o,
  output logic   rd_strobe_o
);

  jsp_rx_if rx_if ();
  jsp_tx_if tx_if ();

  // Word counter handshakes
  logic space_load, space_dec, space_zero;
  logic out_load, out_dec, out_zero;
  logic user_load, user_dec, user_zero;

  //////////////////////////////
  // Control
  //////////////////////////////

  jsp_ctrl ctrl_inst (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .tdi_i           (tdi_i),
    .capture_dr_i    (capture_dr_i),
    .shift_dr_i      (shift_dr_i),
    .update_dr_i     (update_dr_i),
    .module_select_i (module_select_i),
    .rx              (rx_if.ctrl),
    .tx              (tx_if.ctrl),
    .space_load_o    (space_load),
    .space_dec_o     (space_dec),
    .space_zero_i    (space_zero),
    .out_load_o      (out_load),
    .out_dec_o       (out_dec),
    .out_zero_i      (out_zero),
    .user_load_o     (user_load),
    .user_dec_o      (user_dec),
    .user_zero_i     (user_zero),
    .wr_strobe_o     (wr_strobe_o),
    .rd_strobe_o     (rd_strobe_o)
  );

  //////////////////////////////
  // Shift paths
  //////////////////////////////

  jsp_rx_path rx_path_inst (
    .tck_i (tck_i),
    .rst_i (rst_i),
    .tdi_i (tdi_i),
    .rx    (rx_if.path)
  );

  jsp_tx_path tx_path_inst (
    .tck_i         (tck_i),
    .rst_i         (rst_i),
    .rd_byte_i     (rd_byte_i),
    .bytes_avail_i (bytes_avail_i),
    .bytes_free_i  (bytes_free_i),
    .tdo_o         (tdo_o),
    .tx            (tx_if.path)
  );

  assign wr_byte_o = rx_if.rx_byte;

  //////////////////////////////
  // Word counters
  //////////////////////////////

  jsp_word_counter space_cnt_inst (
    .tck_i (tck_i), .rst_i (rst_i),
    .load_i (space_load), .dec_i (space_dec),
    .value_i (bytes_free_i), .zero_o (space_zero)
  );

  jsp_word_counter out_cnt_inst (
    .tck_i (tck_i), .rst_i (rst_i),
    .load_i (out_load), .dec_i (out_dec),
    .value_i (bytes_avail_i), .zero_o (out_zero)
  );

  // Host count is the high nibble of the first assembled byte
  jsp_word_counter user_cnt_inst (
    .tck_i (tck_i), .rst_i (rst_i),
    .load_i (user_load), .dec_i (user_dec),
    .value_i (rx_if.rx_byte[BYTE_W-1 -: CNT_W]), .zero_o (user_zero)
  );

endmodule

// File: bench/jsp_assert.sv
// Strobe rules for the JTAG serial port controller.
// Bound into every jsp_ctrl instance at the bottom of this file.

module jsp_assert (
  input logic tck_i,
  input logic rst_i,
  input logic shift_dr_i,
  input logic wr_strobe_i,
  input logic rd_strobe_i
);

  int fail_cnt = 0;  // Assertion failures so far

  //////////////////////////////
  // Strobes need a shift cycle
  //////////////////////////////

  wr_needs_shift: assert property (@(posedge tck_i) disable iff (rst_i)
    wr_strobe_i |-> shift_dr_i)
    else begin
      $error("wr_strobe_o high without shift_dr_i");
      fail_cnt++;
    end

  rd_needs_shift: assert property (@(posedge tck_i) disable iff (rst_i)
    rd_strobe_i |-> shift_dr_i)
    else begin
      $error("rd_strobe_o high without shift_dr_i");
      fail_cnt++;
    end

  //////////////////////////////
  // One-cycle pulses
  //////////////////////////////

  wr_single: assert property (@(posedge tck_i) disable iff (rst_i)
    wr_strobe_i |=> !wr_strobe_i)  // A byte takes eight shifts
    else begin
      $error("wr_strobe_o high in two consecutive cycles");
      fail_cnt++;
    end

  rd_single: assert property (@(posedge tck_i) disable iff (rst_i)
    rd_strobe_i |=> !rd_strobe_i)
    else begin
      $error("rd_strobe_o high in two consecutive cycles");
      fail_cnt++;
    end

endmodule

bind jsp_ctrl jsp_assert assert_inst (
  .tck_i       (tck_i),
  .rst_i       (rst_i),
  .shift_dr_i  (shift_dr_i),
  .wr_strobe_i (wr_strobe_o),
  .rd_strobe_i (rd_strobe_o)
);

// File: bench/jsp_tb.sv
// Table-driven testbench for the JTAG serial port.
// Each row captures, shifts a host stream on TDI, then checks the TDO bytes,
// the strobe counts and the bytes latched by the bus-side model.

module jsp_tb import jsp_pkg::*; ();

  // One test row, fields in table column order
  typedef struct packed {
    count_t      avail;     // bytes_avail_i
    count_t      free;      // bytes_free_i
    byte_t [3:0] rd;        // Bus read queue, index 0 in the low byte
    logic        start;     // Send the start bit
    count_t      user;      // Count nibble the host announces
    logic [7:0]  n_wr;      // Data bytes sent
    logic [7:0]  n_listed;  // Taken from wr, the rest random
    byte_t [3:0] wr;
    count_t      exp_wr;    // Expected wr_strobe_o pulses
    count_t      exp_rd;    // Expected rd_strobe_o pulses
    logic [7:0]  upd_at;    // Update after this many shifts, 0 for none
  } row_t;

  //   avail free  rd             st    user  nwr   nlst  wr             ewr   erd   upd
  row_t rows [7] = '{
    '{4'd0, 4'd5, 32'h0000_0000, 1'b0, 4'd0, 8'd0, 8'd0, 32'h0000_0000, 4'd0, 4'd0, 8'd0},
    '{4'd2, 4'd3, 32'h0000_3CA5, 1'b0, 4'd0, 8'd0, 8'd0, 32'h0000_0000, 4'd0, 4'd2, 8'd0},
    '{4'd0, 4'd8, 32'h0000_0000, 1'b1, 4'd2, 8'd3, 8'd3, 32'h0033_2211, 4'd2, 4'd0, 8'd0},
    '{4'd1, 4'd1, 32'h0000_005A, 1'b1, 4'd4, 8'd3, 8'd2, 32'h0000_99C3, 4'd1, 4'd1, 8'd0},
    '{4'd0, 4'd6, 32'h0000_0000, 1'b1, 4'd7, 8'd5, 8'd2, 32'h0000_B2E4, 4'd5, 4'd0, 8'd0},
    '{4'd1, 4'd4, 32'h0000_0066, 1'b0, 4'd0, 8'd0, 8'd0, 32'h0000_0000, 4'd0, 4'd1, 8'd0},
    '{4'd2, 4'd4, 32'h0000_F2E1, 1'b1, 4'd3, 8'd2, 8'd2, 32'h0000_8877, 4'd0, 4'd1, 8'd13}
  };
  string names [7] = '{"status_only", "read_two", "user_limit", "free_limit",
                       "data_limit", "no_start", "update_mid"};

  logic   tck_i, rst_i, tdi_i;
  logic   capture_dr_i, shift_dr_i, update_dr_i, module_select_i;
  byte_t  rd_byte_i;
  count_t bytes_avail_i, bytes_free_i;
  logic   tdo_o, wr_strobe_o, rd_strobe_o;
  byte_t  wr_byte_o;

  byte_t  rd_q[$];      // Bus bytes offered to the host
  int     rd_idx;       // Advanced on rd_strobe_o
  byte_t  wr_got[$];    // Latched on wr_strobe_o
  count_t wr_cnt, rd_cnt;
  byte_t  sent[$];      // Data bytes the host sent
  byte_t  tdo_exp[$];
  logic   tdi_bits[$];
  logic   tdo_bits[$];  // TDO as seen before each shift edge
  int     seed;
  int     errors, test_errors;
  string  cur;          // Running test

  jsp_top jsp_top_inst (.*);

  initial tck_i = 1'b0;
  always #5 tck_i = ~tck_i;

  //////////////////////////////
  // Bus-side model
  //////////////////////////////

  // Inputs settle after the rising edge, so the falling edge sees stable strobes
  always @(negedge tck_i) begin
    if (!rst_i && wr_strobe_o) begin
      wr_cnt = wr_cnt + 1'b1;
      wr_got.push_back(wr_byte_o);
    end
    if (!rst_i && rd_strobe_o) begin
      rd_cnt = rd_cnt + 1'b1;
      rd_idx = rd_idx + 1;  // Next byte goes out on the following edge
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic check_byte(input string what, input byte_t exp, input byte_t act);
    if (exp !== act) begin
      $display("mismatch %s %s: expected %h, actual %h", cur, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_count(input string what, input count_t exp, input count_t act);
    if (exp !== act) begin
      $display("mismatch %s %s: expected %0d, actual %0d", cur, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      $display("mismatch %s %s: expected %b, actual %b", cur, what, exp, act);
      test_errors++;
    end
  endtask

  // TDO bits regrouped into bytes, LSB first
  task automatic check_tdo(input int n_bytes);
    byte_t got;
    byte_t exp;
    for (int b = 0; b < n_bytes; b++) begin
      for (int k = 0; k < BYTE_W; k++) begin
        got[k] = tdo_bits[b * BYTE_W + k];
      end
      exp = (b < tdo_exp.size()) ? tdo_exp[b] : 8'h00;  // Zeros after the stream
      check_byte($sformatf("tdo byte %0d", b), exp, got);
    end
  endtask

  //////////////////////////////
  // TAP stimulus
  //////////////////////////////

  task automatic tick(input logic cap, input logic shift, input logic upd, input logic tdi);
    @(posedge tck_i);
    capture_dr_i <= cap;
    shift_dr_i   <= shift;
    update_dr_i  <= upd;
    tdi_i        <= tdi;
    rd_byte_i    <= (rd_idx < rd_q.size()) ? rd_q[rd_idx] : 8'h00;
  endtask

  task automatic shift_bits(input int first, input int last);
    for (int i = first; i < last; i++) begin
      tick(1'b0, 1'b1, 1'b0, (i < tdi_bits.size()) ? tdi_bits[i] : 1'b0);
      @(negedge tck_i);
      tdo_bits.push_back(tdo_o);
    end
    tick(1'b0, 1'b0, 1'b0, 1'b0);  // Pause
  endtask

  task automatic update_dr();
    tick(1'b0, 1'b0, 1'b1, 1'b0);
    tick(1'b0, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic wait_quiet();
    int n;
    n = 0;
    do begin
      @(negedge tck_i);
      n++;
    end while ((wr_strobe_o || rd_strobe_o) && n < 16);
    if (wr_strobe_o || rd_strobe_o) begin
      $display("timeout in %s: strobes still active after update", cur);
      test_errors++;
    end
  endtask

  //////////////////////////////
  // One table row
  //////////////////////////////

  task automatic run_row(input row_t r);
    int    n_shift;
    int    n_bytes;
    int    rnd;
    byte_t host[$];
    rd_q.delete();
    wr_got.delete();
    sent.delete();
    tdi_bits.delete();
    tdo_bits.delete();
    tdo_exp.delete();
    rd_idx = 0;
    wr_cnt = '0;
    rd_cnt = '0;
    for (int i = 0; i < r.avail; i++) begin
      rd_q.push_back(r.rd[i]);
    end
    // Host stream is start bit, count byte, then data, each LSB first
    if (r.start) begin
      rnd = $random(seed);
      tdi_bits.push_back(1'b1);
      host.push_back({r.user, rnd[3:0]});
      for (int i = 0; i < r.n_wr; i++) begin
        rnd = $random(seed);
        host.push_back((i < r.n_listed) ? r.wr[i] : rnd[7:0]);
        sent.push_back(host[i + 1]);
      end
      foreach (host[i]) begin
        for (int k = 0; k < BYTE_W; k++) begin
          tdi_bits.push_back(host[i][k]);
        end
      end
    end
    // Status byte first, then the available bytes
    tdo_exp.push_back({r.avail, r.free});
    for (int i = 0; i < r.avail; i++) begin
      tdo_exp.push_back(r.rd[i]);
    end
    n_shift = BYTE_W * (r.avail + 2);  // Room for one zero byte
    if (tdi_bits.size() > n_shift) begin
      n_shift = tdi_bits.size();
    end
    n_shift = (n_shift + BYTE_W - 1) / BYTE_W * BYTE_W;
    @(posedge tck_i);
    bytes_avail_i <= r.avail;
    bytes_free_i  <= r.free;
    tick(1'b1, 1'b0, 1'b0, 1'b0);  // Capture-DR
    if (r.upd_at != 0) begin
      shift_bits(0, r.upd_at);
      update_dr();
      shift_bits(r.upd_at, n_shift);  // Both channels idle now
      n_bytes = r.upd_at / BYTE_W;
    end else begin
      shift_bits(0, n_shift);
      n_bytes = n_shift / BYTE_W;
    end
    update_dr();
    wait_quiet();
    check_tdo(n_bytes);
    check_count("wr strobes", r.exp_wr, wr_cnt);
    check_count("rd strobes", r.exp_rd, rd_cnt);
    for (int i = 0; i < wr_got.size() && i < sent.size(); i++) begin
      check_byte($sformatf("wr byte %0d", i), sent[i], wr_got[i]);
    end
    // Recapture after an early update shows the status byte again
    if (r.upd_at != 0) begin
      tdi_bits.delete();
      tdo_bits.delete();
      tick(1'b1, 1'b0, 1'b0, 1'b0);
      shift_bits(0, BYTE_W);
      update_dr();
      wait_quiet();
      check_tdo(1);
      check_count("wr strobes after recapture", r.exp_wr, wr_cnt);
      check_count("rd strobes after recapture", r.exp_rd, rd_cnt);
    end
  endtask

  task automatic report_test();
    if (test_errors == 0) begin
      $display("test %s: ok", cur);
    end else begin
      $display("test %s: %0d errors", cur, test_errors);
    end
    errors += test_errors;
    test_errors = 0;
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    seed            = 32'h7241_0009;
    errors          = 0;
    test_errors     = 0;
    rd_idx          = 0;
    wr_cnt          = '0;
    rd_cnt          = '0;
    rst_i           = 1'b1;
    tdi_i           = 1'b0;
    capture_dr_i    = 1'b0;
    shift_dr_i      = 1'b0;
    update_dr_i     = 1'b0;
    module_select_i = 1'b0;
    rd_byte_i       = '0;
    bytes_avail_i   = '0;
    bytes_free_i    = '0;
    repeat (2) @(posedge tck_i);
    rst_i           <= 1'b0;
    module_select_i <= 1'b1;
    cur = "reset";
    @(negedge tck_i);
    check_bit("tdo_o", 1'b0, tdo_o);
    check_bit("wr_strobe_o", 1'b0, wr_strobe_o);
    check_bit("rd_strobe_o", 1'b0, rd_strobe_o);
    report_test();
    for (int t = 0; t < $size(rows); t++) begin
      cur = names[t];
      run_row(rows[t]);
      report_test();
    end
    // Bound strobe rules count toward the result
    if (jsp_top_inst.ctrl_inst.assert_inst.fail_cnt != 0) begin
      $display("%0d strobe assertion failures", jsp_top_inst.ctrl_inst.assert_inst.fail_cnt);
      errors += jsp_top_inst.ctrl_inst.assert_inst.fail_cnt;
    end
    $display("tests %0d, errors %0d", $size(rows) + 1, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: jsp.f
rtl/jsp_pkg.sv
rtl/jsp_if.sv
rtl/jsp_word_counter.sv
rtl/jsp_rx_path.sv
rtl/jsp_tx_path.sv
rtl/jsp_ctrl.sv
rtl/jsp_top.sv
bench/jsp_assert.sv
bench/jsp_tb.sv

// File: Bender.yml
package:
  name: jsp

sources:
  # Design, in compile order
  - rtl/jsp_pkg.sv
  - rtl/jsp_if.sv
  - rtl/jsp_word_counter.sv
  - rtl/jsp_rx_path.sv
  - rtl/jsp_tx_path.sv
  - rtl/jsp_ctrl.sv
  - rtl/jsp_top.sv
  # Testbench and bound assertions
  - target: test
    files:
      - bench/jsp_assert.sv
      - bench/jsp_tb.sv
